// File: all.f
+incdir+include
src/io_pkg.sv
src/addr_decoder.sv
src/ms_timer.sv
src/proc_timers.sv
src/lsb_port.sv
src/sysconf.sv
src/io_subsystem.sv
tests/tb_io_subsystem.sv

// File: Makefile
# Verilator build and run for the i/o subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_io_subsystem
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard src/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/tb_vectors.svh
// i/o subsystem test vectors
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// row: name, addr, wr, wdata, btn_n, swi, idle cycles before the row
// then expected rdata, ram_sel, prom_sel, led_g, led_r, check mask
task automatic load_vectors();
  // ----------------------------------------------------------------------
  // region decode
  // ----------------------------------------------------------------------
  add_vector("ram_zero", 24'h000000, 1'b0, 32'h0, 4'hF, 18'h0, 0,
             32'h0, 1'b1, 1'b0, 8'h00, 18'h0, chk_rdata | chk_sel);
  // last word below the prom
  add_vector("ram_top", 24'hFFDFFC, 1'b0, 32'h0, 4'hF, 18'h0, 0,
             32'h0, 1'b1, 1'b0, 8'h00, 18'h0, chk_rdata | chk_sel);
  add_vector("prom_base", 24'hFFE000, 1'b0, 32'h0, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b1, 8'h00, 18'h0, chk_rdata | chk_sel);
  // upper half of the prom window is neither
  add_vector("prom_upper", 24'hFFE800, 1'b0, 32'h0, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_rdata | chk_sel);
  add_vector("io_unmapped", 24'hFFFF00, 1'b0, 32'h0, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_rdata | chk_sel);

  // ----------------------------------------------------------------------
  // millisecond count
  // ----------------------------------------------------------------------
  add_vector("tmr_sel", tmr_addr, 1'b0, 32'h0, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_ms | chk_sel);
  add_vector("ms_read_a", tmr_addr, 1'b0, 32'h0, 4'hF, 18'h0, 13,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_ms);
  add_vector("ms_read_b", tmr_addr, 1'b0, 32'h0, 4'hF, 18'h0, 41,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_ms);

  // ----------------------------------------------------------------------
  // process timers, periods 1 and 5 enabled
  // ----------------------------------------------------------------------
  add_vector("ptmr_enable", ptmr_addr, 1'b1, 32'h5, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_ptmr);
  add_vector("ptmr_flags", ptmr_addr, 1'b0, 32'h0, 4'hF, 18'h0, 55,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_ptmr);
  add_vector("ptmr_clear", ptmr_addr, 1'b1, 32'h5, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_ptmr);
  add_vector("ptmr_zero", ptmr_addr, 1'b0, 32'h0, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_ptmr);

  // ----------------------------------------------------------------------
  // leds and board inputs
  // ----------------------------------------------------------------------
  // leds still dark on the write cycle
  add_vector("led_write", lsb_addr, 1'b1, 32'h02B3C1A5, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b0, 8'h00, 18'h0, chk_rdata | chk_led);
  add_vector("led_show", lsb_addr, 1'b0, 32'h0, 4'hF, 18'h0, 0,
             32'h0, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_rdata | chk_led);
  // synchronizer still holds the old pins
  add_vector("pins_set", lsb_addr, 1'b0, 32'h0, 4'hA, 18'h25A5A, 0,
             32'h0, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_rdata | chk_led);
  add_vector("pins_read", lsb_addr, 1'b0, 32'h0, 4'hA, 18'h25A5A, 2,
             32'h00165A5A, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_rdata | chk_led);

  // ----------------------------------------------------------------------
  // configuration words, each read shows the index written before
  // ----------------------------------------------------------------------
  add_vector("scfg_wr0", scfg_addr, 1'b1, 32'h0, 4'hA, 18'h25A5A, 0,
             32'h40000, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_rdata);
  add_vector("scfg_wr1", scfg_addr, 1'b1, 32'h1, 4'hA, 18'h25A5A, 0,
             32'h40000, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_rdata);
  add_vector("scfg_wr2", scfg_addr, 1'b1, 32'h2, 4'hA, 18'h25A5A, 0,
             32'h30000, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_rdata);
  add_vector("scfg_wr3", scfg_addr, 1'b1, 32'h3, 4'hA, 18'h25A5A, 0,
             32'h4000, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_rdata);
  add_vector("scfg_rd3", scfg_addr, 1'b0, 32'h0, 4'hA, 18'h25A5A, 0,
             32'h0, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_rdata);
  add_vector("ms_read_c", tmr_addr, 1'b0, 32'h0, 4'hA, 18'h25A5A, 7,
             32'h0, 1'b0, 1'b0, 8'hA5, 18'h2B3C1, chk_ms | chk_sel);
endtask

`endif

// File: tests/tb_io_subsystem.sv
// i/o subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module tb_io_subsystem;

  localparam int clk_per_ms = 10;
  localparam int num_ptmr   = 4;
  localparam int clk_period = 4;
  // slack on top of the table length
  localparam int margin     = 50;

  // check mask bits
  localparam int chk_rdata = 1;
  localparam int chk_ms    = 2;
  localparam int chk_ptmr  = 4;
  localparam int chk_sel   = 8;
  localparam int chk_led   = 16;

  // device word addresses in the i/o block
  localparam logic [23:0] tmr_addr  = {16'hFFFF, io_pkg::slot_tmr, 2'b00};
  localparam logic [23:0] lsb_addr  = {16'hFFFF, io_pkg::slot_lsb, 2'b00};
  localparam logic [23:0] scfg_addr = {16'hFFFF, io_pkg::slot_scfg, 2'b00};
  localparam logic [23:0] ptmr_addr = {16'hFFFF, io_pkg::slot_ptmr, 2'b00};

  // process timer periods in ms
  localparam int period_ms [8] = '{1, 2, 5, 10, 20, 50, 100, 200};

  typedef struct packed {
    logic [io_pkg::addr_w-1:0] addr;
    logic                      wr;
    logic [io_pkg::data_w-1:0] wdata;
    logic [3:0]                btn_n;
    logic [17:0]               swi;
    logic [31:0]               idle;
    logic [io_pkg::data_w-1:0] exp_rdata;
    logic                      exp_ram;
    logic                      exp_prom;
    logic [7:0]                exp_led_g;
    logic [17:0]               exp_led_r;
    logic [31:0]               mask;
  } vec_t;

  logic                      clk;
  logic                      rst_n;
  logic [io_pkg::addr_w-1:0] addr;
  logic                      wr;
  logic [io_pkg::data_w-1:0] wdata;
  logic [io_pkg::data_w-1:0] rdata;
  logic                      ram_sel;
  logic                      prom_sel;
  logic [3:0]                btn_n;
  logic [17:0]               swi;
  logic [7:0]                led_g;
  logic [17:0]               led_r;

  vec_t  vecs[$];
  string names[$];
  // edges since reset release
  int    cycles;
  // edge of the last process timer write and its mask
  int    ptmr_wr_edge;
  logic [num_ptmr-1:0] ptmr_mask;

  io_subsystem #(
    .clk_per_ms(clk_per_ms),
    .num_ptmr(num_ptmr),
    .mem_lim(32'h40000),
    .stack_org(32'h30000),
    .stack_size(32'h4000)
  ) i_io_subsystem (
    .clk(clk), .rst_n(rst_n), .addr(addr), .wr(wr), .wdata(wdata), .rdata(rdata),
    .ram_sel(ram_sel), .prom_sel(prom_sel), .btn_n(btn_n), .swi(swi),
    .led_g(led_g), .led_r(led_r)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    if (!rst_n) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      stop_with_failure($sformatf("CHECK FAILED %s %s expected 'h%0h actual 'h%0h",
                                  name, what, expected, actual));
    end
  endtask

  task automatic add_vector(input string name, input logic [23:0] a, input logic w,
                            input logic [31:0] wd, input logic [3:0] b, input logic [17:0] s,
                            input int idle, input logic [31:0] exp_rd, input logic exp_ram,
                            input logic exp_prom, input logic [7:0] exp_g,
                            input logic [17:0] exp_r, input int mask);
    vec_t v;
    v = '{a, w, wd, b, s, idle, exp_rd, exp_ram, exp_prom, exp_g, exp_r, mask};
    vecs.push_back(v);
    names.push_back(name);
  endtask

  // the tick for ms m lands on edge m * clk_per_ms + 1
  // a tick on the write edge itself is lost to the clear
  function automatic logic [31:0] predict_flags(input int k);
    logic [31:0] flags;
    flags = '0;
    for (int m = 1; m * clk_per_ms + 1 <= k; m++) begin
      if (m * clk_per_ms + 1 > ptmr_wr_edge) begin
        for (int i = 0; i < num_ptmr; i++) begin
          if (ptmr_mask[i] && (m % period_ms[i] == 0)) begin
            flags[i] = 1'b1;
          end
        end
      end
    end
    return flags;
  endfunction

  `include "tb_vectors.svh"

  task automatic apply_vector(input int n);
    vec_t v;
    v = vecs[n];
    repeat (v.idle) begin
      @(posedge clk);
      #1 wr = 1'b0;
    end
    @(posedge clk);
    #1;
    addr  = v.addr;
    wr    = v.wr;
    wdata = v.wdata;
    btn_n = v.btn_n;
    swi   = v.swi;
    // sample just before the next edge
    #2;
    if ((v.mask & chk_rdata) != 0) begin
      check_value(names[n], "rdata", v.exp_rdata, rdata);
    end
    if ((v.mask & chk_ms) != 0) begin
      check_value(names[n], "ms count", cycles / clk_per_ms, rdata);
    end
    if ((v.mask & chk_ptmr) != 0) begin
      check_value(names[n], "ptmr flags", predict_flags(cycles), rdata);
    end
    if ((v.mask & chk_sel) != 0) begin
      check_value(names[n], "ram_sel", {31'b0, v.exp_ram}, {31'b0, ram_sel});
      check_value(names[n], "prom_sel", {31'b0, v.exp_prom}, {31'b0, prom_sel});
    end
    if ((v.mask & chk_led) != 0) begin
      check_value(names[n], "led_g", {24'b0, v.exp_led_g}, {24'b0, led_g});
      check_value(names[n], "led_r", {14'b0, v.exp_led_r}, {14'b0, led_r});
    end
    // write lands on the coming edge
    if (v.wr && (v.addr == ptmr_addr)) begin
      ptmr_mask    = v.wdata[num_ptmr-1:0];
      ptmr_wr_edge = cycles + 1;
    end
  endtask

  task automatic run_watchdog();
    int budget;
    budget = margin;
    foreach (vecs[i]) begin
      budget += vecs[i].idle + 1;
    end
    #(budget * clk_period);
    stop_with_failure("timeout: the vector table did not finish in time");
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    addr         = '0;
    wr           = 1'b0;
    wdata        = '0;
    // buttons released
    btn_n        = 4'hF;
    swi          = '0;
    ptmr_wr_edge = 0;
    ptmr_mask    = '0;
    load_vectors();
    fork
      run_watchdog();
    join_none
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    foreach (vecs[i]) begin
      apply_vector(i);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/io_subsystem.sv
// oberon i/o subsystem top level
`timescale 1ns/10ps
`default_nettype none

module io_subsystem #(
  parameter int clk_per_ms = 25000,
  parameter int num_ptmr = 8,
  parameter logic [io_pkg::data_w-1:0] mem_lim    = 'h40000,
  parameter logic [io_pkg::data_w-1:0] stack_org  = 'h30000,
  parameter logic [io_pkg::data_w-1:0] stack_size = 'h4000
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // bus master
  input  logic [io_pkg::addr_w-1:0] addr,
  input  logic                      wr,
  input  logic [io_pkg::data_w-1:0] wdata,
  output logic [io_pkg::data_w-1:0] rdata,
  // region selects for prom and ram
  output logic                      ram_sel,
  output logic                      prom_sel,
  // board pins
  input  logic [3:0]                btn_n,
  input  logic [17:0]               swi,
  output logic [7:0]                led_g,
  output logic [17:0]               led_r
);

  // device strobes
  logic                      tmr_stb;
  logic                      lsb_stb;
  logic                      scfg_stb;
  logic                      ptmr_stb;
  // device read words
  logic [io_pkg::data_w-1:0] tmr_rdata;
  logic [io_pkg::data_w-1:0] lsb_rdata;
  logic [io_pkg::data_w-1:0] scfg_rdata;
  logic [io_pkg::data_w-1:0] ptmr_rdata;
  // ms timer to process timers
  logic                      ms_tick;
  logic [io_pkg::data_w-1:0] ms_count;

  // ----------------------------------------------------------------------
  // address map
  // ----------------------------------------------------------------------
  addr_decoder dec_0 (
    // in
    .addr(addr), .tmr_rdata(tmr_rdata), .lsb_rdata(lsb_rdata),
    .scfg_rdata(scfg_rdata), .ptmr_rdata(ptmr_rdata),
    // out
    .ram_sel(ram_sel), .prom_sel(prom_sel),
    .tmr_stb(tmr_stb), .lsb_stb(lsb_stb), .scfg_stb(scfg_stb), .ptmr_stb(ptmr_stb),
    .rdata(rdata)
  );

  // ----------------------------------------------------------------------
  // devices
  // ----------------------------------------------------------------------
  // ms timer, slot -64
  ms_timer #(.clk_per_ms(clk_per_ms)) tmr_0 (
    .clk(clk), .rst_n(rst_n), .tmr_stb(tmr_stb),
    .ms_tick(ms_tick), .ms_count(ms_count), .tmr_rdata(tmr_rdata)
  );

  // process timers, slot -132
  proc_timers #(.num_ptmr(num_ptmr)) ptmr_0 (
    .clk(clk), .rst_n(rst_n), .ptmr_stb(ptmr_stb), .wr(wr), .wdata(wdata),
    .ms_tick(ms_tick), .ms_count(ms_count), .ptmr_rdata(ptmr_rdata)
  );

  // leds, switches, buttons, slot -60
  lsb_port lsb_0 (
    .clk(clk), .rst_n(rst_n), .lsb_stb(lsb_stb), .wr(wr), .wdata(wdata),
    .btn_n(btn_n), .swi(swi),
    .lsb_rdata(lsb_rdata), .led_g(led_g), .led_r(led_r)
  );

  // configuration constants, slot -108
  sysconf #(
    .mem_lim(mem_lim),
    .stack_org(stack_org),
    .stack_size(stack_size)
  ) scfg_0 (
    .clk(clk), .rst_n(rst_n), .scfg_stb(scfg_stb), .wr(wr), .wdata(wdata),
    .scfg_rdata(scfg_rdata)
  );

endmodule

`default_nettype wire

// File: src/sysconf.sv
// system configuration word
`timescale 1ns/10ps
`default_nettype none

module sysconf #(
  // ram size
  parameter logic [io_pkg::data_w-1:0] mem_lim    = 'h40000,
  // initial stack pointer
  parameter logic [io_pkg::data_w-1:0] stack_org  = 'h30000,
  parameter logic [io_pkg::data_w-1:0] stack_size = 'h4000
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      scfg_stb,
  input  logic                      wr,
  input  logic [io_pkg::data_w-1:0] wdata,
  output logic [io_pkg::data_w-1:0] scfg_rdata
);

  // which constant the next read returns
  logic [1:0] idx;

  // index write, low two bits only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx <= 2'd0;
    end else if (scfg_stb && wr) begin
      idx <= wdata[1:0];
    end
  end

  // read follows the index at once
  always_comb begin
    case (idx)
      2'd0:    scfg_rdata = mem_lim;
      2'd1:    scfg_rdata = stack_org;
      2'd2:    scfg_rdata = stack_size;
      default: scfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/lsb_port.sv
// leds, switches and buttons
`timescale 1ns/10ps
`default_nettype none

module lsb_port (
  input  logic                      clk,
  input  logic                      rst_n,
  // bus side
  input  logic                      lsb_stb,
  input  logic                      wr,
  input  logic [io_pkg::data_w-1:0] wdata,
  // board pins, buttons active low
  input  logic [3:0]                btn_n,
  input  logic [17:0]               swi,
  // buttons 21:18, switches 17:0
  output logic [io_pkg::data_w-1:0] lsb_rdata,
  output logic [7:0]                led_g,
  output logic [17:0]               led_r
);

  // two stage sync, buttons already inverted
  logic [3:0]  btn_meta;
  logic [3:0]  btn_sync;
  logic [17:0] swi_meta;
  logic [17:0] swi_sync;

  // ----------------------------------------------------------------------
  // input synchronizer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btn_meta <= '0;
      btn_sync <= '0;
      swi_meta <= '0;
      swi_sync <= '0;
    end else begin
      btn_meta <= ~btn_n;
      btn_sync <= btn_meta;
      swi_meta <= swi;
      swi_sync <= swi_meta;
    end
  end

  assign lsb_rdata = {10'b0, btn_sync, swi_sync};

  // ----------------------------------------------------------------------
  // led register
  // ----------------------------------------------------------------------
  // green from bits 7:0, red from bits 25:8
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_g <= '0;
      led_r <= '0;
    end else if (lsb_stb && wr) begin
      led_g <= wdata[7:0];
      led_r <= wdata[25:8];
    end
  end

endmodule

`default_nettype wire

// File: src/proc_timers.sv
// process periodic timers
`timescale 1ns/10ps
`default_nettype none

module proc_timers #(
  // timers in use, up to io_pkg::max_ptmr
  parameter int num_ptmr = 8
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // bus side
  input  logic                      ptmr_stb,
  input  logic                      wr,
  input  logic [io_pkg::data_w-1:0] wdata,
  // from ms timer
  input  logic                      ms_tick,
  input  logic [io_pkg::data_w-1:0] ms_count,
  // ready flags, zero extended
  output logic [io_pkg::data_w-1:0] ptmr_rdata
);

  logic [num_ptmr-1:0] en_mask;
  logic [num_ptmr-1:0] ready;
  logic [num_ptmr-1:0] due;
  logic                wr_en;

  assign wr_en = ptmr_stb && wr;

  // ----------------------------------------------------------------------
  // period match
  // ----------------------------------------------------------------------
  // ms_count already holds the new value while ms_tick is high
  // divisor is a constant per timer
  always_comb begin
    for (int i = 0; i < num_ptmr; i++) begin
      due[i] = en_mask[i] &&
               ((ms_count % {16'h0, io_pkg::ptmr_period[i]}) == '0);
    end
  end

  // ----------------------------------------------------------------------
  // mask and flags
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_mask <= '0;
      ready   <= '0;
    end else if (wr_en) begin
      // new mask, all flags cleared
      en_mask <= wdata[num_ptmr-1:0];
      ready   <= '0;
    end else if (ms_tick) begin
      // sticky until the next write
      ready <= ready | due;
    end
  end

  // flags low, zeros above
  assign ptmr_rdata = {{(io_pkg::data_w - num_ptmr){1'b0}}, ready};

endmodule

`default_nettype wire

// File: src/ms_timer.sv
// millisecond timer
`timescale 1ns/10ps
`default_nettype none

module ms_timer #(
  // clock cycles per millisecond
  parameter int clk_per_ms = 25000
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // slot select, read only device
  input  logic                      tmr_stb,
  // one cycle pulse per ms
  output logic                      ms_tick,
  // ms since reset
  output logic [io_pkg::data_w-1:0] ms_count,
  output logic [io_pkg::data_w-1:0] tmr_rdata
);

  // at least one bit even for clk_per_ms of 1
  localparam int psc_w = (clk_per_ms > 1) ? $clog2(clk_per_ms) : 1;
  localparam logic [psc_w-1:0] psc_last = psc_w'(clk_per_ms - 1);

  logic [psc_w-1:0] psc;
  logic             psc_wrap;

  // last cycle of the current ms
  assign psc_wrap = (psc == psc_last);

  // ----------------------------------------------------------------------
  // prescaler and ms count
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      psc      <= '0;
      ms_count <= '0;
      ms_tick  <= 1'b0;
    end else begin
      // tick follows the increment by one cycle
      ms_tick <= psc_wrap;
      if (psc_wrap) begin
        psc      <= '0;
        ms_count <= ms_count + 1'b1;
      end else begin
        psc <= psc + 1'b1;
      end
    end
  end

  // count visible on the bus only while selected
  assign tmr_rdata = tmr_stb ? ms_count : '0;

endmodule

`default_nettype wire

// File: src/addr_decoder.sv
// bus address decoder and i/o read mux
`timescale 1ns/10ps
`default_nettype none

module addr_decoder (
  // bus address from master
  input  logic [io_pkg::addr_w-1:0] addr,
  // device read words
  input  logic [io_pkg::data_w-1:0] tmr_rdata,
  input  logic [io_pkg::data_w-1:0] lsb_rdata,
  input  logic [io_pkg::data_w-1:0] scfg_rdata,
  input  logic [io_pkg::data_w-1:0] ptmr_rdata,
  // region selects
  output logic                      ram_sel,
  output logic                      prom_sel,
  // device strobes
  output logic                      tmr_stb,
  output logic                      lsb_stb,
  output logic                      scfg_stb,
  output logic                      ptmr_stb,
  // selected read word
  output logic [io_pkg::data_w-1:0] rdata
);

  io_pkg::bus_addr_u bus_addr;
  logic              io_en;

  assign bus_addr = addr;

  // ----------------------------------------------------------------------
  // memory regions
  // ----------------------------------------------------------------------
  // word[21:11] is addr[23:13]
  // ram up to FFE000, 16 MB minus 8 kB
  assign ram_sel = (bus_addr.mem.word[21:11] != io_pkg::ram_limit_prefix);

  // word[21:10] is addr[23:12], word[9] is addr[11]
  // prom in lower half of the 4 kB window
  assign prom_sel = (bus_addr.mem.word[21:10] == io_pkg::prom_prefix) &&
                    !bus_addr.mem.word[9];

  // ----------------------------------------------------------------------
  // i/o slots
  // ----------------------------------------------------------------------
  // one 256 byte block at FFFF00
  assign io_en = (bus_addr.io.block == io_pkg::io_block);

  // one word per device
  assign tmr_stb  = io_en && (bus_addr.io.slot == io_pkg::slot_tmr);
  assign lsb_stb  = io_en && (bus_addr.io.slot == io_pkg::slot_lsb);
  assign scfg_stb = io_en && (bus_addr.io.slot == io_pkg::slot_scfg);
  assign ptmr_stb = io_en && (bus_addr.io.slot == io_pkg::slot_ptmr);

  // ----------------------------------------------------------------------
  // read data
  // ----------------------------------------------------------------------
  // strobes are mutually exclusive
  // unmapped slot or non-i/o address reads zero
  always_comb begin
    rdata = '0;
    if (tmr_stb) begin
      rdata = tmr_rdata;
    end else if (lsb_stb) begin
      rdata = lsb_rdata;
    end else if (scfg_stb) begin
      rdata = scfg_rdata;
    end else if (ptmr_stb) begin
      rdata = ptmr_rdata;
    end
  end

endmodule

`default_nettype wire

// File: src/io_pkg.sv
// i/o subsystem shared definitions
`default_nettype none

package io_pkg;

  // ----------------------------------------------------------------------
  // bus widths
  // ----------------------------------------------------------------------
  localparam int addr_w = 24;
  localparam int data_w = 32;

  // one bus address, two decodings
  typedef union packed {
    // memory view: word index plus byte offset
    struct packed {
      logic [21:0] word;
      logic [1:0]  byte_off;
    } mem;
    // i/o view: block prefix, device slot, byte offset
    struct packed {
      logic [15:0] block;
      logic [5:0]  slot;
      logic [1:0]  byte_off;
    } io;
  } bus_addr_u;

  // ----------------------------------------------------------------------
  // address map
  // ----------------------------------------------------------------------
  // i/o block, 64 word slots at FFFF00
  localparam logic [15:0] io_block = 16'hFFFF;
  // prom at FFE000, lower 2 kB half only
  localparam logic [11:0] prom_prefix = 12'hFFE;
  // everything below FFE000 counts as ram
  localparam logic [10:0] ram_limit_prefix = 11'h7FF;

  // device slots, byte offset from top of block in brackets
  localparam logic [5:0] slot_tmr  = 6'b110000;  // -64
  localparam logic [5:0] slot_lsb  = 6'b110001;  // -60
  localparam logic [5:0] slot_scfg = 6'b100101;  // -108
  localparam logic [5:0] slot_ptmr = 6'b011111;  // -132

  // process timers, periods in ms, entry 0 in the low word
  localparam int max_ptmr = 8;
  localparam logic [max_ptmr-1:0][15:0] ptmr_period = {
    16'd200, 16'd100, 16'd50, 16'd20, 16'd10, 16'd5, 16'd2, 16'd1
  };

endpackage

`default_nettype wire
